//--- hdl/ex_pkg.sv
// Shared definitions for the execute stage
// Word and address widths, vector types, ALU and multiplier opcodes
// and the multiplier state encoding, referenced by scoped names
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Datapath word
  localparam int unsigned DATA_W     = 32;
  // Register file write address, 64 entries
  localparam int unsigned REG_ADDR_W = 6;
  // Opcode widths
  localparam int unsigned ALU_OP_W   = 3;
  localparam int unsigned MULT_OP_W  = 1;

  // Default latency of the high-word multiply, in cycles
  localparam int unsigned MULH_CYCLES_DEFAULT = 3;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [ALU_OP_W-1:0]   alu_op_t;
  typedef logic [MULT_OP_W-1:0]  mult_op_t;

  // ALU operation codes
  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;
  localparam alu_op_t ALU_SLL = 3'd5;
  localparam alu_op_t ALU_SRL = 3'd6;
  // Branch-equal compare
  localparam alu_op_t ALU_EQ  = 3'd7;

  // Multiplier operation codes
  localparam mult_op_t MUL_LO = 1'b0;
  localparam mult_op_t MUL_HI = 1'b1;

  // Multiplier sequencing for the high word
  typedef enum logic {
    MULT_IDLE,
    MULT_BUSY
  } mult_state_e;

endpackage

//--- hdl/ex_alu.sv
// Integer ALU of the execute stage
// Add, subtract, logic ops, shifts and the equality compare for branches
// Purely combinational, result forced to zero while not enabled
module ex_alu (
  input  logic            alu_en_i,
  input  ex_pkg::alu_op_t alu_operator_i,
  input  ex_pkg::data_t   alu_operand_a_i,
  input  ex_pkg::data_t   alu_operand_b_i,
  output ex_pkg::data_t   alu_result_o,
  output logic            alu_cmp_o
);

  //////////////////////////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////////////////////////

  // Subtract shares the adder, B inverted plus carry-in
  logic          is_sub;
  ex_pkg::data_t adder_b;
  ex_pkg::data_t adder_sum;

  assign is_sub    = (alu_operator_i == ex_pkg::ALU_SUB);
  assign adder_b   = is_sub ? ~alu_operand_b_i : alu_operand_b_i;
  assign adder_sum = alu_operand_a_i + adder_b + ex_pkg::data_t'(is_sub);

  //////////////////////////////////////////////////////////////////////
  // Shifter and comparator
  //////////////////////////////////////////////////////////////////////

  // Shift amount from low five bits of B
  logic [4:0]    shamt;
  ex_pkg::data_t shift_left;
  ex_pkg::data_t shift_right;
  logic          operands_eq;

  assign shamt       = alu_operand_b_i[4:0];
  assign shift_left  = alu_operand_a_i << shamt;
  // Logical shift, zeros come in from the top
  assign shift_right = alu_operand_a_i >> shamt;

  assign operands_eq = (alu_operand_a_i == alu_operand_b_i);

  // Branch decision only for the compare opcode
  assign alu_cmp_o = alu_en_i && (alu_operator_i == ex_pkg::ALU_EQ) && operands_eq;

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_result_o = '0;
    // Idle cycles keep the result bus quiet
    if (alu_en_i) begin
      case (alu_operator_i)
        ex_pkg::ALU_ADD,
        ex_pkg::ALU_SUB: alu_result_o = adder_sum;
        ex_pkg::ALU_AND: alu_result_o = alu_operand_a_i & alu_operand_b_i;
        ex_pkg::ALU_OR:  alu_result_o = alu_operand_a_i | alu_operand_b_i;
        ex_pkg::ALU_XOR: alu_result_o = alu_operand_a_i ^ alu_operand_b_i;
        ex_pkg::ALU_SLL: alu_result_o = shift_left;
        ex_pkg::ALU_SRL: alu_result_o = shift_right;
        // Compare flag zero-extended into the word
        ex_pkg::ALU_EQ:  alu_result_o = ex_pkg::data_t'(operands_eq);
        default:         alu_result_o = '0;
      endcase
    end
  end

endmodule

//--- hdl/ex_mult.sv
// Signed multiplier of the execute stage
// Low word of the product returns in the same cycle, the high word
// waits MULH_CYCLES-1 stall cycles before ready goes back up
module ex_mult #(
  parameter int unsigned MULH_CYCLES = 3
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             mult_en_i,
  input  ex_pkg::mult_op_t mult_operator_i,
  input  ex_pkg::data_t    mult_operand_a_i,
  input  ex_pkg::data_t    mult_operand_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::data_t    mult_result_o,
  output logic             mult_ready_o,
  output logic             mult_multicycle_o
);

  // Counter sized to reach MULH_CYCLES-1
  localparam int unsigned CNT_W = $clog2(MULH_CYCLES) + 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MULH_CYCLES - 1);

  //////////////////////////////////////////////////////////////////////
  // Product
  //////////////////////////////////////////////////////////////////////

  logic signed [2*ex_pkg::DATA_W-1:0] product;
  logic                               hi_req;

  // Both operands signed, low word is the same as unsigned
  assign product = $signed(mult_operand_a_i) * $signed(mult_operand_b_i);
  assign hi_req  = mult_en_i && (mult_operator_i == ex_pkg::MUL_HI);

  always_comb begin
    mult_result_o = '0;
    if (mult_en_i) begin
      if (mult_operator_i == ex_pkg::MUL_HI) begin
        mult_result_o = product[2*ex_pkg::DATA_W-1:ex_pkg::DATA_W];
      end else begin
        mult_result_o = product[ex_pkg::DATA_W-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // High-word sequencer
  //////////////////////////////////////////////////////////////////////

  ex_pkg::mult_state_e state_q;
  ex_pkg::mult_state_e state_d;
  logic [CNT_W-1:0]    cnt_q;
  logic [CNT_W-1:0]    cnt_d;

  always_comb begin
    state_d           = state_q;
    cnt_d             = cnt_q;
    mult_ready_o      = 1'b1;
    mult_multicycle_o = 1'b0;
    case (state_q)
      ex_pkg::MULT_IDLE: begin
        // First cycle of a high-word request already stalls
        if (hi_req && (MULH_CYCLES > 1)) begin
          mult_ready_o      = 1'b0;
          mult_multicycle_o = 1'b1;
          cnt_d             = CNT_W'(1);
          state_d           = ex_pkg::MULT_BUSY;
        end
      end
      ex_pkg::MULT_BUSY: begin
        if (cnt_q < CNT_LAST) begin
          mult_ready_o      = 1'b0;
          mult_multicycle_o = 1'b1;
          cnt_d             = cnt_q + 1'b1;
        end else if (ex_ready_i) begin
          // Result presented and EX advances
          cnt_d   = '0;
          state_d = ex_pkg::MULT_IDLE;
        end
        // Otherwise hold under back-pressure
      end
      default: begin
        cnt_d   = '0;
        state_d = ex_pkg::MULT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

endmodule

//--- hdl/ex_fwd_mux.sv
// Forwarding write-port mux of the execute stage
// Picks CSR, multiplier or ALU data for the ALU register-file port
// and the ID-stage bypass; enable and address pass straight through
module ex_fwd_mux (
  input  logic               alu_en_i,
  input  logic               mult_en_i,
  input  logic               csr_access_i,
  input  logic               regfile_alu_we_i,
  input  ex_pkg::reg_addr_t  regfile_alu_waddr_i,
  input  ex_pkg::data_t      alu_result_i,
  input  ex_pkg::data_t      mult_result_i,
  input  ex_pkg::data_t      csr_rdata_i,
  output logic               regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t  regfile_alu_waddr_fw_o,
  output ex_pkg::data_t      regfile_alu_wdata_fw_o
);

  // Write control from decode unchanged
  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  //////////////////////////////////////////////////////////////////////
  // Data select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Priority CSR, then multiplier, then ALU
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      // Nothing selected
      regfile_alu_wdata_fw_o = '0;
    end
  end

endmodule

//--- hdl/ex_wb_pipe.sv
// Stall control and EX/WB register of the execute stage
// Builds ex_ready/ex_valid from the unit ready flags and write-back
// ready, and registers the load/store write-back enable and address
module ex_wb_pipe (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o
);

  //////////////////////////////////////////////////////////////////////
  // Ready and valid
  //////////////////////////////////////////////////////////////////////

  logic units_ready;
  logic ex_active;
  logic wb_we_gated;

  // All units done and write-back can take the result
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign ex_active   = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches finish in EX, no write-back needed
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid does not look at ready, avoids a loop through decode
  assign ex_valid_o = ex_active & units_ready;

  // Faulting access never writes the register file
  assign wb_we_gated = regfile_we_i & ~lsu_err_i;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o    <= 1'b0;
      regfile_waddr_wb_o <= '0;
    end else begin
      if (ex_valid_o) begin
        regfile_we_wb_o <= wb_we_gated;
        // Address only moves with a real write
        if (wb_we_gated) begin
          regfile_waddr_wb_o <= regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        // WB ready but nothing completes, flush the slot
        regfile_we_wb_o <= 1'b0;
      end
      // Otherwise hold under back-pressure
    end
  end

endmodule

//--- hdl/ex_stage_top.sv
// Execute stage top level
// Wires ALU, multiplier, forwarding mux and EX/WB stall logic together
// and to the decode, load/store, write-back and fetch interfaces
module ex_stage_top #(
  parameter int unsigned MULH_CYCLES = ex_pkg::MULH_CYCLES_DEFAULT
) (
  input  logic              clk,
  input  logic              rst_n,

  // ALU operands and control from decode
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_t   alu_operator_i,
  input  ex_pkg::data_t     alu_operand_a_i,
  input  ex_pkg::data_t     alu_operand_b_i,
  input  ex_pkg::data_t     alu_operand_c_i,

  // Multiplier operands and control
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_t  mult_operator_i,
  input  ex_pkg::data_t     mult_operand_a_i,
  input  ex_pkg::data_t     mult_operand_b_i,
  output logic              mult_multicycle_o,

  // Load/store unit
  input  logic              lsu_en_i,
  input  ex_pkg::data_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              lsu_err_i,

  // Register write control from decode
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  // CSR read data
  input  logic              csr_access_i,
  input  ex_pkg::data_t     csr_rdata_i,

  // Load/store write-back port
  output logic              regfile_we_wb_o,
  output ex_pkg::reg_addr_t regfile_waddr_wb_o,
  output ex_pkg::data_t     regfile_wdata_wb_o,

  // Forwarding port to register file and decode
  output logic              regfile_alu_we_fw_o,
  output ex_pkg::reg_addr_t regfile_alu_waddr_fw_o,
  output ex_pkg::data_t     regfile_alu_wdata_fw_o,

  // Branch resolution to fetch
  output ex_pkg::data_t     jump_target_o,
  output logic              branch_decision_o,

  // Pipeline handshake
  output logic              ex_ready_o,
  output logic              ex_valid_o,
  input  logic              wb_ready_i
);

  ex_pkg::data_t alu_result;
  logic          alu_cmp;
  ex_pkg::data_t mult_result;
  logic          mult_ready;
  logic          ex_ready;

  // Branch outputs straight from the compare and operand C
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_operand_c_i;

  // Load data goes to write-back unregistered
  assign regfile_wdata_wb_o = lsu_rdata_i;

  assign ex_ready_o = ex_ready;

  //////////////////////////////////////////////////////////////////////
  // Datapath units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .alu_en_i        (alu_en_i),
    .alu_operator_i  (alu_operator_i),
    .alu_operand_a_i (alu_operand_a_i),
    .alu_operand_b_i (alu_operand_b_i),
    .alu_result_o    (alu_result),
    .alu_cmp_o       (alu_cmp)
  );

  // Ready feedback lets the multiplier leave BUSY only as EX advances
  ex_mult #(
    .MULH_CYCLES (MULH_CYCLES)
  ) u_mult (
    .clk               (clk),
    .rst_n             (rst_n),
    .mult_en_i         (mult_en_i),
    .mult_operator_i   (mult_operator_i),
    .mult_operand_a_i  (mult_operand_a_i),
    .mult_operand_b_i  (mult_operand_b_i),
    .ex_ready_i        (ex_ready),
    .mult_result_o     (mult_result),
    .mult_ready_o      (mult_ready),
    .mult_multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Write ports and stall control
  //////////////////////////////////////////////////////////////////////

  ex_fwd_mux u_fwd_mux (
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o)
  );

  ex_wb_pipe u_wb_pipe (
    .clk                (clk),
    .rst_n              (rst_n),
    .alu_en_i           (alu_en_i),
    .mult_en_i          (mult_en_i),
    .csr_access_i       (csr_access_i),
    .lsu_en_i           (lsu_en_i),
    .mult_ready_i       (mult_ready),
    .lsu_ready_ex_i     (lsu_ready_ex_i),
    .lsu_err_i          (lsu_err_i),
    .wb_ready_i         (wb_ready_i),
    .branch_in_ex_i     (branch_in_ex_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .ex_ready_o         (ex_ready),
    .ex_valid_o         (ex_valid_o),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o)
  );

endmodule

//--- include/tb_ex_vectors.svh
// Stimulus table for the execute stage testbench, included in its module
// Columns: name, enables {alu, mult, mulhi, csr, lsu}, ALU op, A, B, CSR data,
// flags {regfile_we, wb_ready, lsu_ready, lsu_err, branch_in_ex},
// random operands, expected forwarded data, expected branch decision
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

task automatic load_table();
  add_row("add_fix", 5'b10000, ex_pkg::ALU_ADD, 32'h5, 32'h7, 0, 5'b11100, 0, 32'hC, 0);
  add_row("sub_fix", 5'b10000, ex_pkg::ALU_SUB, 32'h3, 32'h5, 0, 5'b01100, 0, 32'hFFFFFFFE, 0);
  add_row("and_fix", 5'b10000, ex_pkg::ALU_AND, 32'hF0F0F0F0, 32'h0FF00FF0, 0, 5'b01100, 0,
          32'h00F000F0, 0);
  add_row("or_fix", 5'b10000, ex_pkg::ALU_OR, 32'hF0F0F0F0, 32'h0FF00FF0, 0, 5'b01100, 0,
          32'hFFF0FFF0, 0);
  add_row("xor_fix", 5'b10000, ex_pkg::ALU_XOR, 32'hF0F0F0F0, 32'h0FF00FF0, 0, 5'b01100, 0,
          32'hFF00FF00, 0);
  add_row("sll_fix", 5'b10000, ex_pkg::ALU_SLL, 32'h1, 32'h24, 0, 5'b01100, 0, 32'h10, 0);
  add_row("srl_fix", 5'b10000, ex_pkg::ALU_SRL, 32'h80000000, 32'h1F, 0, 5'b01100, 0, 32'h1, 0);
  // Branch taken while write-back is stalled
  add_row("eq_taken", 5'b10000, ex_pkg::ALU_EQ, 32'h1234, 32'h1234, 0, 5'b00101, 0, 32'h1, 1);
  add_row("eq_not", 5'b10000, ex_pkg::ALU_EQ, 32'h1234, 32'h1235, 0, 5'b01100, 0, 32'h0, 0);
  add_row("mul_lo", 5'b01000, ex_pkg::ALU_ADD, 32'hFFFFFFFF, 32'h3, 0, 5'b01100, 0,
          32'hFFFFFFFD, 0);
  add_row("mulh_neg", 5'b01100, ex_pkg::ALU_ADD, 32'hFFFFFFFF, 32'h3, 0, 5'b01100, 0,
          32'hFFFFFFFF, 0);
  add_row("mulh_pos", 5'b01100, ex_pkg::ALU_ADD, 32'h40000000, 32'h8, 0, 5'b01100, 0, 32'h2, 0);
  add_row("prio_csr", 5'b11010, ex_pkg::ALU_ADD, 32'h6, 32'h7, 32'hCAFE0001, 5'b01100, 0,
          32'hCAFE0001, 0);
  add_row("prio_mult", 5'b11000, ex_pkg::ALU_ADD, 32'h6, 32'h7, 0, 5'b01100, 0, 32'h2A, 0);
  // Write-back register: load, hold, clear, error
  add_row("lsu_load", 5'b00001, ex_pkg::ALU_ADD, 0, 0, 0, 5'b11100, 0, 32'h0, 0);
  add_row("wb_stall", 5'b10000, ex_pkg::ALU_ADD, 32'h1, 32'h1, 0, 5'b10100, 0, 32'h2, 0);
  add_row("lsu_stall", 5'b10000, ex_pkg::ALU_ADD, 32'h1, 32'h1, 0, 5'b11000, 0, 32'h2, 0);
  add_row("lsu_err", 5'b00001, ex_pkg::ALU_ADD, 0, 0, 0, 5'b11110, 0, 32'h0, 0);
  add_row("add_rnd", 5'b10000, ex_pkg::ALU_ADD, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("sub_rnd", 5'b10000, ex_pkg::ALU_SUB, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("xor_rnd", 5'b10000, ex_pkg::ALU_XOR, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("sll_rnd", 5'b10000, ex_pkg::ALU_SLL, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("srl_rnd", 5'b10000, ex_pkg::ALU_SRL, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("eq_rnd", 5'b10000, ex_pkg::ALU_EQ, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("mul_lo_rnd", 5'b01000, ex_pkg::ALU_ADD, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("mulh_rnd", 5'b01100, ex_pkg::ALU_ADD, 0, 0, 0, 5'b11100, 1, 0, 0);
  add_row("idle", 5'b00000, ex_pkg::ALU_ADD, 0, 0, 0, 5'b01100, 0, 32'h0, 0);
endtask

`endif

//--- sim/tb_ex_stage.sv
// Testbench for the execute stage top level
// Applies the vector table row by row, checks the forwarding port, branch
// outputs, handshake and EX/WB register against a reference model
module tb_ex_stage;

  localparam int MULH_CYCLES  = ex_pkg::MULH_CYCLES_DEFAULT;
  localparam int RESET_CYCLES = 10;

  // One table row, columns as in the vector header
  typedef struct {
    string           name;
    logic [4:0]      en;
    ex_pkg::alu_op_t alu_op;
    ex_pkg::data_t   a;
    ex_pkg::data_t   b;
    ex_pkg::data_t   csr;
    logic [4:0]      flags;
    bit              rnd;
    ex_pkg::data_t   exp_data;
    logic            exp_br;
  } row_t;

  row_t rows[$];
  int   errors;
  int   cycles;
  int   cycle_limit;

  logic clk;
  logic rst_n;
  logic alu_en_i, mult_en_i, lsu_en_i, lsu_ready_ex_i, lsu_err_i, csr_access_i;
  logic branch_in_ex_i, regfile_alu_we_i, regfile_we_i, wb_ready_i;
  ex_pkg::alu_op_t   alu_operator_i;
  ex_pkg::mult_op_t  mult_operator_i;
  ex_pkg::data_t     alu_operand_a_i, alu_operand_b_i, alu_operand_c_i;
  ex_pkg::data_t     mult_operand_a_i, mult_operand_b_i, lsu_rdata_i, csr_rdata_i;
  ex_pkg::reg_addr_t regfile_alu_waddr_i, regfile_waddr_i;
  logic mult_multicycle_o, regfile_we_wb_o, regfile_alu_we_fw_o;
  logic branch_decision_o, ex_ready_o, ex_valid_o;
  ex_pkg::reg_addr_t regfile_waddr_wb_o, regfile_alu_waddr_fw_o;
  ex_pkg::data_t     regfile_wdata_wb_o, regfile_alu_wdata_fw_o, jump_target_o;

  ex_stage_top #(.MULH_CYCLES(MULH_CYCLES)) dut (.*);

  `include "tb_ex_vectors.svh"

  //////////////////////////////////////////////////////////////////////
  // Clock and run limit
  //////////////////////////////////////////////////////////////////////

  always #5 clk = ~clk;

  // Run limit from the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("ERROR: simulation ran past %0d cycles without finishing", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Table, compare and reference model
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(string name, logic [4:0] en, ex_pkg::alu_op_t op,
                         ex_pkg::data_t a, ex_pkg::data_t b, ex_pkg::data_t csr,
                         logic [4:0] flags, bit rnd, ex_pkg::data_t exp_data,
                         logic exp_br);
    row_t r;
    r.name = name;
    r.en = en;
    r.alu_op = op;
    r.a = a;
    r.b = b;
    r.csr = csr;
    r.flags = flags;
    r.rnd = rnd;
    r.exp_data = exp_data;
    r.exp_br = exp_br;
    rows.push_back(r);
  endtask

  task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  // Reference result by the forwarding priority and operation rules
  function automatic ex_pkg::data_t model_result(row_t r, ex_pkg::data_t a, ex_pkg::data_t b);
    logic [63:0] p;
    // Sign-extended operands, low 64 bits equal the signed product
    p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    if (r.en[1]) return r.csr;
    if (r.en[3]) return r.en[2] ? p[63:32] : p[31:0];
    if (!r.en[4]) return '0;
    case (r.alu_op)
      ex_pkg::ALU_ADD: return a + b;
      ex_pkg::ALU_SUB: return a - b;
      ex_pkg::ALU_AND: return a & b;
      ex_pkg::ALU_OR:  return a | b;
      ex_pkg::ALU_XOR: return a ^ b;
      ex_pkg::ALU_SLL: return a << b[4:0];
      ex_pkg::ALU_SRL: return a >> b[4:0];
      default:         return {31'b0, a == b};
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus and checks
  //////////////////////////////////////////////////////////////////////

  initial begin
    row_t r;
    ex_pkg::data_t a, b, exp_data;
    logic exp_br, exp_valid, exp_ready, m_we, hi;
    ex_pkg::reg_addr_t m_addr, waddr;
    int stalls;
    void'($urandom(32'h79481ef1));
    errors = 0;
    cycles = 0;
    cycle_limit = 1000;
    clk = 0;
    rst_n = 0;
    {alu_en_i, mult_en_i, lsu_en_i, lsu_err_i, csr_access_i, branch_in_ex_i} = '0;
    {regfile_alu_we_i, regfile_we_i, lsu_ready_ex_i, wb_ready_i} = 4'b0011;
    alu_operator_i = ex_pkg::ALU_ADD;
    mult_operator_i = ex_pkg::MUL_LO;
    {alu_operand_a_i, alu_operand_b_i, alu_operand_c_i} = '0;
    {mult_operand_a_i, mult_operand_b_i, lsu_rdata_i, csr_rdata_i} = '0;
    regfile_alu_waddr_i = '0;
    regfile_waddr_i = '0;
    // EX/WB register model starts from its reset state
    m_we = 0;
    m_addr = '0;
    load_table();
    cycle_limit = rows.size() * (MULH_CYCLES + 4) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1;
    foreach (rows[i]) begin
      r = rows[i];
      a = r.rnd ? ex_pkg::data_t'($urandom) : r.a;
      b = r.rnd ? ex_pkg::data_t'($urandom) : r.b;
      exp_data = r.rnd ? model_result(r, a, b) : r.exp_data;
      exp_br = r.rnd ? (r.en[4] && r.alu_op == ex_pkg::ALU_EQ && a == b) : r.exp_br;
      waddr = ex_pkg::reg_addr_t'(i + 1);
      hi = r.en[3] & r.en[2];
      @(posedge clk);
      alu_en_i <= r.en[4];
      mult_en_i <= r.en[3];
      mult_operator_i <= r.en[2] ? ex_pkg::MUL_HI : ex_pkg::MUL_LO;
      csr_access_i <= r.en[1];
      lsu_en_i <= r.en[0];
      alu_operator_i <= r.alu_op;
      // Row operands go only to the unit under test
      // Other unit gets random operands
      alu_operand_a_i <= r.en[3] ? ex_pkg::data_t'($urandom) : a;
      alu_operand_b_i <= r.en[3] ? ex_pkg::data_t'($urandom) : b;
      mult_operand_a_i <= r.en[3] ? a : ex_pkg::data_t'($urandom);
      mult_operand_b_i <= r.en[3] ? b : ex_pkg::data_t'($urandom);
      alu_operand_c_i <= $urandom;
      lsu_rdata_i <= $urandom;
      csr_rdata_i <= r.csr;
      // Forwarding controls kept apart from the write-back controls
      regfile_alu_we_i <= 1'($urandom);
      regfile_we_i <= r.flags[4];
      regfile_alu_waddr_i <= ~waddr;
      regfile_waddr_i <= waddr;
      wb_ready_i <= r.flags[3];
      lsu_ready_ex_i <= r.flags[2];
      lsu_err_i <= r.flags[1];
      branch_in_ex_i <= r.flags[0];
      stalls = 0;
      @(negedge clk);
      // High word: count stall cycles until the result is presented
      while (hi && !ex_valid_o && stalls < MULH_CYCLES + 2) begin
        check_value(r.name, "ex_ready_o stall", 0, ex_ready_o);
        check_value(r.name, "mult_multicycle_o", 1, mult_multicycle_o);
        check_value(r.name, "regfile_we_wb_o", m_we, regfile_we_wb_o);
        m_we = 0;
        stalls++;
        @(negedge clk);
      end
      if (hi) begin
        check_value(r.name, "stall cycles", MULH_CYCLES - 1, stalls);
        if (!ex_valid_o) begin
          errors++;
          $display("ERROR: %s ex_valid_o never rose for the high-word multiply", r.name);
        end
      end
      // Handshake by the ready and valid rules
      exp_ready = (r.flags[3] & r.flags[2]) | r.flags[0];
      exp_valid = (|{r.en[4:3], r.en[1:0]}) & r.flags[3] & r.flags[2];
      check_value(r.name, "fw data", exp_data, regfile_alu_wdata_fw_o);
      check_value(r.name, "fw we", regfile_alu_we_i, regfile_alu_we_fw_o);
      check_value(r.name, "fw waddr", regfile_alu_waddr_i, regfile_alu_waddr_fw_o);
      check_value(r.name, "branch_decision_o", exp_br, branch_decision_o);
      check_value(r.name, "jump_target_o", alu_operand_c_i, jump_target_o);
      check_value(r.name, "wb wdata", lsu_rdata_i, regfile_wdata_wb_o);
      check_value(r.name, "ex_ready_o", exp_ready, ex_ready_o);
      check_value(r.name, "ex_valid_o", exp_valid, ex_valid_o);
      check_value(r.name, "mult_multicycle_o", 0, mult_multicycle_o);
      check_value(r.name, "regfile_we_wb_o", m_we, regfile_we_wb_o);
      check_value(r.name, "regfile_waddr_wb_o", m_addr, regfile_waddr_wb_o);
      // EX/WB register reference for the next edge
      if (exp_valid) begin
        m_we = r.flags[4] & ~r.flags[1];
        if (m_we) m_addr = waddr;
      end else if (r.flags[3]) begin
        m_we = 0;
      end
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_mult.sv
hdl/ex_fwd_mux.sv
hdl/ex_wb_pipe.sv
hdl/ex_stage_top.sv
sim/tb_ex_stage.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary -Wno-fatal -f flist.f --top-module tb_ex_stage -o Vtb_ex_stage
	./obj_dir/Vtb_ex_stage > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Test completed successfully" $(LOG) || (echo "Simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
